//--- source/mdu_div.sv
// *******************************************************************
// Restoring long divider for DIV, DIVU, REM and REMU with its own
// 33-bit subtractor for absolute values, compare and sign fix
// *******************************************************************

module mdu_div
  import mdu_pkg::*;
#(
  parameter bit EarlyDivZero = 1'b1
) (
  input  logic    clk_i,
  input  logic    rst_ni,
  input  logic    start_i,
  input  md_req_t req_i,
  input  logic    ack_i,
  output logic    done_o,
  output word_t   result_o
);

  localparam logic [4:0] LastCount = 5'(DivSteps - 1);

  div_state_e  state_q;
  div_state_e  state_d;
  logic        go_q;
  logic        div_zero_q;
  logic [4:0]  cnt_q;

  // Captured request
  md_op_e      op_q;
  word_t       op_a_q;
  word_t       op_b_q;

  logic        is_rem;
  logic        is_signed;
  logic        sign_a;
  logic        sign_b;
  logic        b_zero;
  logic        neg_res;

  // Working registers
  word_t       num_q;
  word_t       den_q;
  word_t       rem_q;
  word_t       quo_q;
  word_t       res_q;

  logic [32:0] sub_a;
  logic [32:0] sub_b;
  logic [32:0] sub_res;
  logic [32:0] shifted;
  logic        ge;
  word_t       next_rem;
  word_t       next_quo;

  assign is_rem    = (op_q == MD_REM) || (op_q == MD_REMU);
  assign is_signed = (op_q == MD_DIV) || (op_q == MD_REM);
  assign sign_a    = is_signed & op_a_q[31];
  assign sign_b    = is_signed & op_b_q[31];
  assign b_zero    = (op_b_q == '0);

  // Quotient sign flips on differing signs, never for a zero divisor
  assign neg_res = is_rem ? sign_a : ((sign_a ^ sign_b) & ~div_zero_q);

  // Partial remainder with the next dividend bit shifted in
  assign shifted = {rem_q, num_q[31]};

  always_comb begin
    sub_a = '0;
    sub_b = '0;
    unique case (state_q)
      DIV_ABS_A: sub_b = {1'b0, op_a_q};
      DIV_ABS_B: sub_b = {1'b0, op_b_q};
      DIV_COMP,
      DIV_LAST: begin
        sub_a = shifted;
        sub_b = {1'b0, den_q};
      end
      DIV_SIGN:  sub_b = {1'b0, res_q};
      default:   sub_b = '0;
    endcase
  end

  assign sub_res = sub_a - sub_b;

  // A set top bit means shifted is at least 2^32 and thus above any divisor
  assign ge       = shifted[32] | ~sub_res[32];
  assign next_rem = ge ? sub_res[31:0] : shifted[31:0];
  assign next_quo = {quo_q[30:0], ge};

  always_comb begin
    state_d = state_q;
    unique case (state_q)
      DIV_IDLE: begin
        if (go_q) begin
          state_d = (EarlyDivZero && b_zero) ? DIV_FINISH : DIV_ABS_A;
        end
      end
      DIV_ABS_A: state_d = DIV_ABS_B;
      DIV_ABS_B: state_d = DIV_COMP;
      DIV_COMP: begin
        if (cnt_q == 5'd1) begin
          state_d = DIV_LAST;
        end
      end
      DIV_LAST:  state_d = DIV_SIGN;
      DIV_SIGN:  state_d = DIV_FINISH;
      DIV_FINISH: begin
        // Result stays until the response is taken
        if (ack_i) begin
          state_d = DIV_IDLE;
        end
      end
      default:   state_d = DIV_IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q    <= DIV_IDLE;
      go_q       <= 1'b0;
      div_zero_q <= 1'b0;
      cnt_q      <= '0;
    end else begin
      state_q <= state_d;
      go_q    <= start_i;
      if (go_q) begin
        div_zero_q <= b_zero;
      end
      if (state_q == DIV_ABS_B) begin
        cnt_q <= LastCount;
      end else if (state_q == DIV_COMP) begin
        cnt_q <= cnt_q - 5'd1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (start_i) begin
      op_q   <= req_i.op;
      op_a_q <= req_i.op_a;
      op_b_q <= req_i.op_b;
    end

    case (state_q)
      DIV_IDLE: begin
        // Divide by zero, either taken as final or overwritten by the full run
        if (go_q && b_zero) begin
          res_q <= is_rem ? op_a_q : '1;
        end
      end
      DIV_ABS_A: begin
        num_q <= sign_a ? sub_res[31:0] : op_a_q;
      end
      DIV_ABS_B: begin
        den_q <= sign_b ? sub_res[31:0] : op_b_q;
        rem_q <= '0;
      end
      DIV_COMP: begin
        rem_q <= next_rem;
        quo_q <= next_quo;
        num_q <= {num_q[30:0], 1'b0};
      end
      DIV_LAST: begin
        res_q <= is_rem ? next_rem : next_quo;
      end
      DIV_SIGN: begin
        if (neg_res) begin
          res_q <= sub_res[31:0];
        end
      end
      default: begin
      end
    endcase
  end

  assign done_o   = (state_q == DIV_FINISH);
  assign result_o = res_q;

endmodule

//--- source/mdu_mult.sv
// *******************************************************************
// Iterative multiplier for MUL, MULH, MULHSU and MULHU built on one
// signed 17x17 multiply-accumulate, one quarter product per cycle
// *******************************************************************

module mdu_mult
  import mdu_pkg::*;
(
  input  logic    clk_i,
  input  logic    rst_ni,
  input  logic    start_i,
  input  md_req_t req_i,
  input  logic    ack_i,
  output logic    done_o,
  output word_t   result_o
);

  mult_state_e        state_q;
  mult_state_e        state_d;
  logic               running_q;
  logic               done_q;
  logic               step_last;

  // Captured request
  md_op_e             op_q;
  word_t              op_a_q;
  word_t              op_b_q;

  logic               low_word;
  logic               signed_a;
  logic               signed_b;

  // MAC operands and result
  logic [15:0]        mul_a;
  logic [15:0]        mul_b;
  logic               sign_a;
  logic               sign_b;
  logic [33:0]        accum;
  logic signed [33:0] mac_res;

  logic [33:0]        acc_q;
  logic [33:0]        acc_d;
  word_t              result_q;
  word_t              result_d;

  assign low_word = (op_q == MD_MUL);
  assign signed_a = (op_q == MD_MULH) || (op_q == MD_MULHSU);
  assign signed_b = (op_q == MD_MULH);

  // Both operand halves get a 17th bit, so one signed multiplier serves all modes
  assign mac_res = $signed({sign_a, mul_a}) * $signed({sign_b, mul_b}) + $signed(accum);

  always_comb begin
    mul_a     = op_a_q[15:0];
    mul_b     = op_b_q[15:0];
    sign_a    = 1'b0;
    sign_b    = 1'b0;
    accum     = '0;
    acc_d     = mac_res;
    result_d  = mac_res[31:0];
    state_d   = state_q;
    step_last = 1'b0;

    unique case (state_q)
      ALBL: begin
        state_d = ALBH;
      end

      ALBH: begin
        mul_b  = op_b_q[31:16];
        sign_b = signed_b & op_b_q[31];
        // al*bl is unsigned, only its upper half carries on
        accum  = {18'b0, acc_q[31:16]};
        if (low_word) begin
          acc_d = {2'b0, mac_res[15:0], acc_q[15:0]};
        end
        state_d = AHBL;
      end

      AHBL: begin
        mul_a  = op_a_q[31:16];
        sign_a = signed_a & op_a_q[31];
        if (low_word) begin
          accum     = {18'b0, acc_q[31:16]};
          result_d  = {mac_res[15:0], acc_q[15:0]};
          step_last = 1'b1;
        end else begin
          accum   = acc_q;
          state_d = AHBH;
        end
      end

      AHBH: begin
        mul_a     = op_a_q[31:16];
        mul_b     = op_b_q[31:16];
        sign_a    = signed_a & op_a_q[31];
        sign_b    = signed_b & op_b_q[31];
        // Arithmetic shift of the partial sum by 16
        accum     = {{16{acc_q[33]}}, acc_q[33:16]};
        step_last = 1'b1;
      end

      default: begin
        state_d = ALBL;
      end
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q   <= ALBL;
      running_q <= 1'b0;
      done_q    <= 1'b0;
    end else if (start_i) begin
      state_q   <= ALBL;
      running_q <= 1'b1;
    end else if (running_q) begin
      state_q <= state_d;
      if (step_last) begin
        running_q <= 1'b0;
        done_q    <= 1'b1;
      end
    end else if (done_q && ack_i) begin
      done_q  <= 1'b0;
      state_q <= ALBL;
    end
  end

  always_ff @(posedge clk_i) begin
    if (start_i) begin
      op_q   <= req_i.op;
      op_a_q <= req_i.op_a;
      op_b_q <= req_i.op_b;
    end
    if (running_q) begin
      acc_q <= acc_d;
    end
    if (running_q && step_last) begin
      result_q <= result_d;
    end
  end

  assign done_o   = done_q;
  assign result_o = result_q;

endmodule

//--- source/mdu_pkg.sv
// *******************************************************************
// Shared types for the RV32M multiply/divide unit: opcode and FSM
// state enums, the word type, request and response structs
// *******************************************************************

package mdu_pkg;

  // Operand and result word
  typedef logic [31:0] word_t;

  // M-extension opcodes, bit 2 set for the divide class
  typedef enum logic [2:0] {
    MD_MUL    = 3'b000,
    MD_MULH   = 3'b001,
    MD_MULHSU = 3'b010,
    MD_MULHU  = 3'b011,
    MD_DIV    = 3'b100,
    MD_DIVU   = 3'b101,
    MD_REM    = 3'b110,
    MD_REMU   = 3'b111
  } md_op_e;

  typedef struct packed {
    md_op_e op;
    word_t  op_a;
    word_t  op_b;
  } md_req_t;

  typedef struct packed {
    word_t result;
  } md_rsp_t;

  // Quarter products of the iterative multiplier
  typedef enum logic [1:0] {
    ALBL, ALBH, AHBL, AHBH
  } mult_state_e;

  typedef enum logic [2:0] {
    DIV_IDLE, DIV_ABS_A, DIV_ABS_B, DIV_COMP, DIV_LAST, DIV_SIGN, DIV_FINISH
  } div_state_e;

  // Quotient bits produced by the divider
  localparam int unsigned DivSteps      = 32;
  // Start to done for MUL and for the high-word variants
  localparam int unsigned MulLowCycles  = 3;
  localparam int unsigned MulHighCycles = 4;

endpackage

//--- source/mdu_top.sv
// *******************************************************************
// RV32M multiply/divide unit top: valid/ready request acceptance,
// routing to the multiplier or divider, response return
// *******************************************************************

module mdu_top
  import mdu_pkg::*;
#(
  parameter bit EarlyDivZero = 1'b1
) (
  input  logic    clk_i,
  input  logic    rst_ni,
  input  logic    req_valid_i,
  output logic    req_ready_o,
  input  md_req_t req_i,
  output logic    rsp_valid_o,
  input  logic    rsp_ready_i,
  output md_rsp_t rsp_o
);

  logic  busy_q;
  logic  owner_div_q;
  logic  accept;
  logic  sel_div;

  logic  mult_start;
  logic  mult_ack;
  logic  mult_done;
  word_t mult_result;

  logic  div_start;
  logic  div_ack;
  logic  div_done;
  word_t div_result;

  // One operation in flight
  assign req_ready_o = ~busy_q;
  assign accept      = req_valid_i & req_ready_o;
  assign sel_div     = req_i.op[2];

  assign mult_start = accept & ~sel_div;
  assign div_start  = accept & sel_div;

  assign mult_ack = rsp_ready_i & ~owner_div_q;
  assign div_ack  = rsp_ready_i & owner_div_q;

  assign rsp_valid_o  = owner_div_q ? div_done : mult_done;
  assign rsp_o.result = owner_div_q ? div_result : mult_result;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      busy_q      <= 1'b0;
      owner_div_q <= 1'b0;
    end else if (accept) begin
      busy_q      <= 1'b1;
      owner_div_q <= sel_div;
    end else if (rsp_valid_o && rsp_ready_i) begin
      busy_q <= 1'b0;
    end
  end

  mdu_mult u_mult (
    .clk_i    (clk_i),
    .rst_ni   (rst_ni),
    .start_i  (mult_start),
    .req_i    (req_i),
    .ack_i    (mult_ack),
    .done_o   (mult_done),
    .result_o (mult_result)
  );

  mdu_div #(
    .EarlyDivZero (EarlyDivZero)
  ) u_div (
    .clk_i    (clk_i),
    .rst_ni   (rst_ni),
    .start_i  (div_start),
    .req_i    (req_i),
    .ack_i    (div_ack),
    .done_o   (div_done),
    .result_o (div_result)
  );

endmodule

//--- verif/mdu_asserts.sv
// *******************************************************************
// Checker bound into mdu_top: reference model for RV32M results,
// latency, and request/response handshake assertions
// *******************************************************************

module mdu_asserts
  import mdu_pkg::*;
#(
  parameter bit EarlyDivZero = 1'b1
) (
  input logic    clk_i,
  input logic    rst_ni,
  input logic    req_valid_i,
  input logic    req_ready_o,
  input md_req_t req_i,
  input logic    rsp_valid_o,
  input logic    rsp_ready_i,
  input md_rsp_t rsp_o
);

  timeunit 1ns;
  timeprecision 1ps;

  // Start to done for a full divide: two abs steps, the iterations, the sign step
  localparam int unsigned DivCycles     = DivSteps + 4;
  localparam int unsigned DivZeroCycles = EarlyDivZero ? 1 : DivCycles;

  int    result_errs = 0;
  int    timing_errs = 0;
  int    proto_errs  = 0;

  logic  accept;
  logic  handshake;
  logic  pending_q;
  md_req_t exp_req_q;
  word_t exp_res_q;

  // Truncating RV32M semantics, including divide by zero and overflow
  function automatic word_t expected_result(input md_req_t req);
    logic signed [63:0] prod;
    word_t a;
    word_t b;
    a = req.op_a;
    b = req.op_b;
    case (req.op)
      MD_MUL:    prod = $signed({32'b0, a}) * $signed({32'b0, b});
      MD_MULH:   prod = $signed({{32{a[31]}}, a}) * $signed({{32{b[31]}}, b});
      MD_MULHSU: prod = $signed({{32{a[31]}}, a}) * $signed({32'b0, b});
      default:   prod = $signed({32'b0, a}) * $signed({32'b0, b});
    endcase
    case (req.op)
      MD_MUL:    return prod[31:0];
      MD_MULH,
      MD_MULHSU,
      MD_MULHU:  return prod[63:32];
      MD_DIV: begin
        if (b == '0) return '1;
        if (a == 32'h8000_0000 && b == '1) return a;
        return $signed(a) / $signed(b);
      end
      MD_DIVU:   return (b == '0) ? '1 : a / b;
      MD_REM: begin
        if (b == '0) return a;
        if (a == 32'h8000_0000 && b == '1) return '0;
        return $signed(a) % $signed(b);
      end
      default:   return (b == '0) ? a : a % b;
    endcase
  endfunction

  assign accept    = req_valid_i && req_ready_o;
  assign handshake = rsp_valid_o && rsp_ready_i;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      pending_q <= 1'b0;
      exp_req_q <= '0;
      exp_res_q <= '0;
    end else if (accept) begin
      pending_q <= 1'b1;
      exp_req_q <= req_i;
      exp_res_q <= expected_result(req_i);
    end else if (handshake) begin
      pending_q <= 1'b0;
    end
  end

  // Results on the response handshake
  a_mult_result: assert property (@(posedge clk_i) disable iff (!rst_ni)
    handshake && !exp_req_q.op[2] |-> rsp_o.result == exp_res_q)
  else begin
    result_errs++;
    $error("MISMATCH %0t: multiply expected %h observed %h",
           $time, $sampled(exp_res_q), $sampled(rsp_o.result));
  end

  a_div_result: assert property (@(posedge clk_i) disable iff (!rst_ni)
    handshake && exp_req_q.op[2] && exp_req_q.op_b != '0 |-> rsp_o.result == exp_res_q)
  else begin
    result_errs++;
    $error("MISMATCH %0t: divide expected %h observed %h",
           $time, $sampled(exp_res_q), $sampled(rsp_o.result));
  end

  a_div_zero: assert property (@(posedge clk_i) disable iff (!rst_ni)
    handshake && exp_req_q.op[2] && exp_req_q.op_b == '0 |-> rsp_o.result == exp_res_q)
  else begin
    result_errs++;
    $error("MISMATCH %0t: divide by zero expected %h observed %h",
           $time, $sampled(exp_res_q), $sampled(rsp_o.result));
  end

  // Latency from acceptance to the rise of rsp_valid_o
  a_mul_low_lat: assert property (@(posedge clk_i) disable iff (!rst_ni)
    accept && req_i.op == MD_MUL |=> !rsp_valid_o [*MulLowCycles] ##1 rsp_valid_o)
  else begin
    timing_errs++;
    $error("MUL response did not arrive after %0d cycles", MulLowCycles);
  end

  a_mul_high_lat: assert property (@(posedge clk_i) disable iff (!rst_ni)
    accept && !req_i.op[2] && req_i.op != MD_MUL
      |=> !rsp_valid_o [*MulHighCycles] ##1 rsp_valid_o)
  else begin
    timing_errs++;
    $error("high-word multiply response did not arrive after %0d cycles", MulHighCycles);
  end

  a_div_lat: assert property (@(posedge clk_i) disable iff (!rst_ni)
    accept && req_i.op[2] && req_i.op_b != '0 |=> !rsp_valid_o [*DivCycles] ##1 rsp_valid_o)
  else begin
    timing_errs++;
    $error("divide response did not arrive after %0d cycles", DivCycles);
  end

  a_div_zero_lat: assert property (@(posedge clk_i) disable iff (!rst_ni)
    accept && req_i.op[2] && req_i.op_b == '0
      |=> !rsp_valid_o [*DivZeroCycles] ##1 rsp_valid_o)
  else begin
    timing_errs++;
    $error("divide by zero response did not arrive after %0d cycles", DivZeroCycles);
  end

  // Handshake rules
  a_reset_state: assert property (@(posedge clk_i)
    $rose(rst_ni) |-> req_ready_o && !rsp_valid_o)
  else begin
    proto_errs++;
    $error("ready or valid wrong when leaving reset");
  end

  a_rsp_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
    rsp_valid_o && !rsp_ready_i |=> rsp_valid_o && $stable(rsp_o))
  else begin
    proto_errs++;
    $error("response dropped or changed while stalled");
  end

  a_busy_ready: assert property (@(posedge clk_i) disable iff (!rst_ni)
    pending_q |-> !req_ready_o)
  else begin
    proto_errs++;
    $error("req_ready_o high while an operation is in flight");
  end

  a_rsp_owned: assert property (@(posedge clk_i) disable iff (!rst_ni)
    rsp_valid_o |-> pending_q)
  else begin
    proto_errs++;
    $error("rsp_valid_o high with no operation in flight");
  end

endmodule

bind mdu_top mdu_asserts #(.EarlyDivZero(EarlyDivZero)) u_asserts (.*);

//--- verif/mdu_tb.sv
// *******************************************************************
// Testbench for mdu_top with clock and reset, directed corner cases,
// LFSR driven random operations with back-pressure, timeout and verdict
// *******************************************************************

module mdu_tb
  import mdu_pkg::*;
();

  timeunit 1ns;
  timeprecision 1ps;

  localparam int unsigned NumDirected   = 128;
  localparam int unsigned NumRandom     = 176;
  // Budget of 40 cycles per operation with margin for long stalls
  localparam int unsigned TimeoutCycles = (NumDirected + NumRandom) * 40 + 2000;

  logic    clk_i;
  logic    rst_ni;
  logic    req_valid_i;
  logic    req_ready_o;
  md_req_t req_i;
  logic    rsp_valid_o;
  logic    rsp_ready_i;
  md_rsp_t rsp_o;

  logic [31:0] lfsr_q;
  int unsigned cycle_cnt;
  int unsigned rsp_count;
  int          total_errs;

  mdu_top dut0 (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .req_valid_i (req_valid_i),
    .req_ready_o (req_ready_o),
    .req_i       (req_i),
    .rsp_valid_o (rsp_valid_o),
    .rsp_ready_i (rsp_ready_i),
    .rsp_o       (rsp_o)
  );

  always #4 clk_i = ~clk_i;

  // Taps 32, 22, 2, 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    logic fb;
    fb = s[31] ^ s[21] ^ s[1] ^ s[0];
    return {s[30:0], fb};
  endfunction

  function automatic logic [31:0] rand_bits(input int unsigned n);
    logic [31:0] val;
    val = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_q = lfsr_next(lfsr_q);
      val    = {val[30:0], lfsr_q[0]};
    end
    return val;
  endfunction

  // Issue one request and wait for its response handshake
  task automatic send_op(input md_op_e op, input word_t a, input word_t b);
    md_req_t     req;
    int unsigned stall;
    req.op   = op;
    req.op_a = a;
    req.op_b = b;
    req_valid_i <= 1'b1;
    req_i       <= req;
    @(posedge clk_i);
    while (!req_ready_o) begin
      @(posedge clk_i);
    end
    req_valid_i <= 1'b0;
    // Now and then hold the response long past any latency
    stall = (rand_bits(3) == 0) ? 40 : 0;
    do begin
      if (stall > 0) begin
        rsp_ready_i <= 1'b0;
        stall--;
      end else begin
        rsp_ready_i <= (rand_bits(2) != 0);
      end
      @(posedge clk_i);
    end while (!(rsp_valid_o && rsp_ready_i));
    rsp_count++;
  endtask

  // Every opcode against signed corners, zero and minus one divisors
  task automatic run_directed();
    word_t dir_a [4];
    word_t dir_b [4];
    dir_a = '{32'd7, 32'hffff_fff9, 32'h8000_0000, 32'h7fff_ffff};
    dir_b = '{32'd2, 32'hffff_fffe, 32'h0000_0000, 32'hffff_ffff};
    for (int o = 0; o < 8; o++) begin
      for (int i = 0; i < 4; i++) begin
        for (int j = 0; j < 4; j++) begin
          send_op(md_op_e'(o[2:0]), dir_a[i], dir_b[j]);
        end
      end
    end
  endtask

  task automatic run_random();
    logic [2:0] op_bits;
    logic [2:0] b_mode;
    word_t      a;
    word_t      b;
    for (int n = 0; n < NumRandom; n++) begin
      op_bits = 3'(rand_bits(3));
      a       = rand_bits(32);
      b       = rand_bits(32);
      b_mode  = 3'(rand_bits(3));
      if (b_mode == 3'd0) begin
        b = '0;
      end else if (b_mode == 3'd1) begin
        b = rand_bits(4);
      end
      send_op(md_op_e'(op_bits), a, b);
    end
  endtask

  always @(posedge clk_i) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= TimeoutCycles) begin
      $display("timeout: responses stopped arriving");
      $display("TEST FAILED");
      $finish;
    end
  end

  initial begin
    clk_i       = 1'b0;
    rst_ni      = 1'b0;
    req_valid_i = 1'b0;
    req_i       = '0;
    rsp_ready_i = 1'b0;
    lfsr_q      = 32'h3d87_2e96;
    cycle_cnt   = 0;
    rsp_count   = 0;

    repeat (10) @(posedge clk_i);
    rst_ni <= 1'b1;
    @(posedge clk_i);

    run_directed();
    run_random();

    // Let the last assertions settle
    repeat (4) @(posedge clk_i);
    total_errs = dut0.u_asserts.result_errs + dut0.u_asserts.timing_errs
               + dut0.u_asserts.proto_errs;
    $display("%0d responses, %0d result errors, %0d latency errors, %0d handshake errors",
             rsp_count, dut0.u_asserts.result_errs, dut0.u_asserts.timing_errs,
             dut0.u_asserts.proto_errs);
    if (total_errs == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

//--- verilog.f
source/mdu_pkg.sv
source/mdu_mult.sv
source/mdu_div.sv
source/mdu_top.sv
verif/mdu_asserts.sv
verif/mdu_tb.sv
